/* rv_pkg.sv */
package rv_pkg;

    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int imm_w      = 12;

    // alu opcodes, 4 bits.
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_sll = 4'd5,
        op_srl = 4'd6,
        op_sra = 4'd7,
        op_slt = 4'd8
    } alu_op_e;

    // one in-flight producer, seen by operand fetch.
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       value;
    } fwd_tap_t;

endpackage

/* issue_if.sv */
`timescale 1ns/1ps

interface issue_if;

    logic                          valid;
    rv_pkg::alu_op_e               op;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [rv_pkg::xlen-1:0]       opa;
    logic [rv_pkg::xlen-1:0]       opb;

    // no handshake, valid alone marks an instruction.
    modport source (
        output valid,
        output op,
        output rd,
        output opa,
        output opb
    );

    modport sink (
        input valid,
        input op,
        input rd,
        input opa,
        input opb
    );

endinterface

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_pkg::xlen-1:0]       rdata1,
    output logic [rv_pkg::xlen-1:0]       rdata2,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0]       wdata
);

    logic [rv_pkg::xlen-1:0] regs [rv_pkg::num_regs];

    // architectural state starts at zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired.
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

/* operand_fwd.sv */
`timescale 1ns/1ps

module operand_fwd (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_valid,
    input  rv_pkg::alu_op_e               instr_op,
    input  logic [rv_pkg::reg_addr_w-1:0] instr_rd,
    input  logic [rv_pkg::reg_addr_w-1:0] instr_rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] instr_rs2,
    input  logic                          instr_use_imm,
    input  logic [rv_pkg::imm_w-1:0]      instr_imm,
    output logic [rv_pkg::reg_addr_w-1:0] rf_raddr1,
    output logic [rv_pkg::reg_addr_w-1:0] rf_raddr2,
    input  logic [rv_pkg::xlen-1:0]       rf_rdata1,
    input  logic [rv_pkg::xlen-1:0]       rf_rdata2,
    input  rv_pkg::fwd_tap_t              ex_tap,
    input  rv_pkg::fwd_tap_t              mem_tap,
    input  rv_pkg::fwd_tap_t              wb_tap,
    issue_if.source                       iss
);

    logic [rv_pkg::xlen-1:0] opa;
    logic [rv_pkg::xlen-1:0] rs2_val;
    logic [rv_pkg::xlen-1:0] imm_sext;
    logic [rv_pkg::xlen-1:0] opb;

    // youngest matching producer wins, else the register file.
    function automatic logic [rv_pkg::xlen-1:0] pick_operand(
        input logic [rv_pkg::reg_addr_w-1:0] rs,
        input logic [rv_pkg::xlen-1:0]       rf_val,
        input rv_pkg::fwd_tap_t              ex,
        input rv_pkg::fwd_tap_t              mem,
        input rv_pkg::fwd_tap_t              wb
    );
        logic [rv_pkg::xlen-1:0] val;
        if (rs == '0) begin
            val = '0;
        end else if (ex.valid && (ex.rd == rs)) begin
            val = ex.value;
        end else if (mem.valid && (mem.rd == rs)) begin
            val = mem.value;
        end else if (wb.valid && (wb.rd == rs)) begin
            val = wb.value;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign rf_raddr1 = instr_rs1;
    assign rf_raddr2 = instr_rs2;

    assign imm_sext = {{(rv_pkg::xlen - rv_pkg::imm_w){instr_imm[rv_pkg::imm_w-1]}}, instr_imm};

    assign opa     = pick_operand(instr_rs1, rf_rdata1, ex_tap, mem_tap, wb_tap);
    assign rs2_val = pick_operand(instr_rs2, rf_rdata2, ex_tap, mem_tap, wb_tap);
    assign opb     = instr_use_imm ? imm_sext : rs2_val;

    // id/ex register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss.valid <= 1'b0;
            iss.op    <= rv_pkg::op_add;
            iss.rd    <= '0;
            iss.opa   <= '0;
            iss.opb   <= '0;
        end else begin
            iss.valid <= instr_valid;
            iss.op    <= instr_op;
            iss.rd    <= instr_rd;
            iss.opa   <= opa;
            iss.opb   <= opb;
        end
    end

endmodule

/* alu_stage.sv */
`timescale 1ns/1ps

module alu_stage (
    input  logic             clk,
    input  logic             rst_n,
    issue_if.sink            iss,
    output rv_pkg::fwd_tap_t ex_tap,
    output rv_pkg::fwd_tap_t mem_tap
);

    logic [rv_pkg::xlen-1:0] result;
    logic [5:0]              shamt;
    logic                    lt;

    assign shamt = iss.opb[5:0];
    assign lt    = $signed(iss.opa) < $signed(iss.opb);

    always_comb begin
        case (iss.op)
            rv_pkg::op_add: result = iss.opa + iss.opb;
            rv_pkg::op_sub: result = iss.opa - iss.opb;
            rv_pkg::op_and: result = iss.opa & iss.opb;
            rv_pkg::op_or:  result = iss.opa | iss.opb;
            rv_pkg::op_xor: result = iss.opa ^ iss.opb;
            rv_pkg::op_sll: result = iss.opa << shamt;
            rv_pkg::op_srl: result = iss.opa >> shamt;
            rv_pkg::op_sra: result = $signed(iss.opa) >>> shamt;
            rv_pkg::op_slt: result = {{(rv_pkg::xlen - 1){1'b0}}, lt};
            default:        result = '0;
        endcase
    end

    // result is visible to operand fetch in the same cycle.
    always_comb begin
        ex_tap.valid = iss.valid;
        ex_tap.rd    = iss.rd;
        ex_tap.value = result;
    end

    // ex/mem register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_tap <= '0;
        end else begin
            mem_tap <= ex_tap;
        end
    end

endmodule

/* retire_stage.sv */
`timescale 1ns/1ps

module retire_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  rv_pkg::fwd_tap_t              mem_tap,
    output rv_pkg::fwd_tap_t              wb_tap,
    output logic                          rf_we,
    output logic [rv_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [rv_pkg::xlen-1:0]       rf_wdata,
    output logic                          wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data
);

    rv_pkg::fwd_tap_t wb_q;

    // mem/wb register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= mem_tap;
        end
    end

    assign wb_tap = wb_q;

    // regfile takes the value at the edge closing wb.
    assign rf_we    = wb_q.valid;
    assign rf_waddr = wb_q.rd;
    assign rf_wdata = wb_q.value;

    assign wb_valid = wb_q.valid;
    assign wb_rd    = wb_q.rd;
    assign wb_data  = wb_q.value;

endmodule

/* fwd_core.sv */
`timescale 1ns/1ps

module fwd_core (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_valid,
    input  rv_pkg::alu_op_e               instr_op,
    input  logic [rv_pkg::reg_addr_w-1:0] instr_rd,
    input  logic [rv_pkg::reg_addr_w-1:0] instr_rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] instr_rs2,
    input  logic                          instr_use_imm,
    input  logic [rv_pkg::imm_w-1:0]      instr_imm,
    output logic                          wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data
);

    logic [rv_pkg::reg_addr_w-1:0] rf_raddr1;
    logic [rv_pkg::reg_addr_w-1:0] rf_raddr2;
    logic [rv_pkg::xlen-1:0]       rf_rdata1;
    logic [rv_pkg::xlen-1:0]       rf_rdata2;
    logic                          rf_we;
    logic [rv_pkg::reg_addr_w-1:0] rf_waddr;
    logic [rv_pkg::xlen-1:0]       rf_wdata;
    rv_pkg::fwd_tap_t              ex_tap;
    rv_pkg::fwd_tap_t              mem_tap;
    rv_pkg::fwd_tap_t              wb_tap;

    issue_if iss ();

    regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    operand_fwd u_operand_fwd (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr_op      (instr_op),
        .instr_rd      (instr_rd),
        .instr_rs1     (instr_rs1),
        .instr_rs2     (instr_rs2),
        .instr_use_imm (instr_use_imm),
        .instr_imm     (instr_imm),
        .rf_raddr1     (rf_raddr1),
        .rf_raddr2     (rf_raddr2),
        .rf_rdata1     (rf_rdata1),
        .rf_rdata2     (rf_rdata2),
        .ex_tap        (ex_tap),
        .mem_tap       (mem_tap),
        .wb_tap        (wb_tap),
        .iss           (iss.source)
    );

    alu_stage u_alu_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .iss     (iss.sink),
        .ex_tap  (ex_tap),
        .mem_tap (mem_tap)
    );

    retire_stage u_retire_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem_tap  (mem_tap),
        .wb_tap   (wb_tap),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

/* fwd_core_props.sv */
`timescale 1ns/1ps

module fwd_core_props (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          instr_valid,
    input logic [rv_pkg::reg_addr_w-1:0] instr_rs1,
    input rv_pkg::fwd_tap_t              ex_tap,
    input rv_pkg::fwd_tap_t              mem_tap,
    input rv_pkg::fwd_tap_t              wb_tap,
    input logic                          wb_valid,
    input logic [rv_pkg::xlen-1:0]       iss_opa
);

    logic x0_tap_live;

    // some producer aimed at x0 carries a nonzero value.
    assign x0_tap_live = (ex_tap.valid && ex_tap.rd == '0 && ex_tap.value != '0) ||
                         (mem_tap.valid && mem_tap.rd == '0 && mem_tap.value != '0) ||
                         (wb_tap.valid && wb_tap.rd == '0 && wb_tap.value != '0);

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_valid)
        else $error("wb_valid high during reset");

    fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid == $past(instr_valid, 3))
        else $error("wb_valid does not follow instr_valid by three cycles");

    x0_not_forwarded: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_valid && instr_rs1 == '0 && x0_tap_live) |=> (iss_opa == '0))
        else $error("x0 operand picked up a forwarded value");

endmodule

bind fwd_core fwd_core_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_rs1   (instr_rs1),
    .ex_tap      (ex_tap),
    .mem_tap     (mem_tap),
    .wb_tap      (wb_tap),
    .wb_valid    (wb_valid),
    .iss_opa     (iss.opa)
);

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    localparam int num_random = 2000;
    // reset, directed part and drain fit well inside the margin.
    localparam int max_cycles = num_random + 1000;

    logic                          clk;
    logic                          rst_n;
    logic                          instr_valid;
    rv_pkg::alu_op_e               instr_op;
    logic [rv_pkg::reg_addr_w-1:0] instr_rd;
    logic [rv_pkg::reg_addr_w-1:0] instr_rs1;
    logic [rv_pkg::reg_addr_w-1:0] instr_rs2;
    logic                          instr_use_imm;
    logic [rv_pkg::imm_w-1:0]      instr_imm;
    logic                          wb_valid;
    logic [rv_pkg::reg_addr_w-1:0] wb_rd;
    logic [rv_pkg::xlen-1:0]       wb_data;

    logic [63:0] model_regs [32];
    logic [68:0] exp_q [$];
    logic [68:0] exp_entry;
    int          seed = 32'ha3b2_e076;
    int          cycles = 0;
    int          sent = 0;
    int          retired = 0;
    logic [4:0]  r_rd;
    logic [4:0]  r_rs1;
    logic [4:0]  r_rs2;
    logic [3:0]  r_op;
    logic        r_use_imm;
    logic [11:0] r_imm;

    fwd_core dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr_op      (instr_op),
        .instr_rd      (instr_rd),
        .instr_rs1     (instr_rs1),
        .instr_rs2     (instr_rs2),
        .instr_use_imm (instr_use_imm),
        .instr_imm     (instr_imm),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // rv64 alu semantics, shifts use 6 bits of b.
    function automatic logic [63:0] alu_ref(input rv_pkg::alu_op_e op,
                                            input logic [63:0] a, input logic [63:0] b);
        logic [63:0] r;
        case (op)
            rv_pkg::op_add: r = a + b;
            rv_pkg::op_sub: r = a - b;
            rv_pkg::op_and: r = a & b;
            rv_pkg::op_or:  r = a | b;
            rv_pkg::op_xor: r = a ^ b;
            rv_pkg::op_sll: r = a << b[5:0];
            rv_pkg::op_srl: r = a >> b[5:0];
            rv_pkg::op_sra: r = $signed(a) >>> b[5:0];
            rv_pkg::op_slt: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            default:        r = 64'd0;
        endcase
        return r;
    endfunction

    // drives one slot and runs the model in program order.
    task automatic send_instr(input logic v, input rv_pkg::alu_op_e op, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic use_imm, input logic [11:0] imm);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        @(posedge clk);
        #1;
        instr_valid   = v;
        instr_op      = op;
        instr_rd      = rd;
        instr_rs1     = rs1;
        instr_rs2     = rs2;
        instr_use_imm = use_imm;
        instr_imm     = imm;
        if (v) begin
            a = (rs1 == 5'd0) ? 64'd0 : model_regs[rs1];
            b = (rs2 == 5'd0) ? 64'd0 : model_regs[rs2];
            if (use_imm) begin
                b = {{52{imm[11]}}, imm};
            end
            r = alu_ref(op, a, b);
            exp_q.push_back({rd, r});
            sent++;
            if (rd != 5'd0) begin
                model_regs[rd] = r;
            end
        end
    endtask

    task automatic issue_rr(input rv_pkg::alu_op_e op, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2);
        send_instr(1'b1, op, rd, rs1, rs2, 1'b0, 12'd0);
    endtask

    task automatic issue_ri(input rv_pkg::alu_op_e op, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [11:0] imm);
        send_instr(1'b1, op, rd, rs1, 5'd0, 1'b1, imm);
    endtask

    task automatic bubble();
        send_instr(1'b0, rv_pkg::op_add, 5'd0, 5'd0, 5'd0, 1'b0, 12'd0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // outputs settle after the rising edge.
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                abort_run("a retirement was seen with no instruction outstanding");
            end else begin
                exp_entry = exp_q.pop_front();
                check_value("wb_rd", 64'(wb_rd), 64'(exp_entry[68:64]));
                check_value("wb_data", wb_data, exp_entry[63:0]);
                retired++;
            end
        end
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        instr_valid   = 1'b0;
        instr_op      = rv_pkg::op_add;
        instr_rd      = '0;
        instr_rs1     = '0;
        instr_rs2     = '0;
        instr_use_imm = 1'b0;
        instr_imm     = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 64'd0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) bubble();
        check_value("wb_valid after reset", 64'(wb_valid), 64'd0);

        // registers still hold zero.
        issue_rr(rv_pkg::op_add, 5'd1, 5'd2, 5'd3);
        issue_rr(rv_pkg::op_or, 5'd4, 5'd5, 5'd6);

        // back-to-back chain through ex on both operands.
        issue_ri(rv_pkg::op_add, 5'd1, 5'd0, 12'h7ff);
        repeat (4) issue_rr(rv_pkg::op_add, 5'd1, 5'd1, 5'd1);
        issue_rr(rv_pkg::op_sll, 5'd1, 5'd1, 5'd1);
        issue_rr(rv_pkg::op_sub, 5'd1, 5'd1, 5'd1);

        // distance 2 and 3.
        issue_ri(rv_pkg::op_add, 5'd2, 5'd0, 12'h123);
        bubble();
        issue_rr(rv_pkg::op_sub, 5'd3, 5'd2, 5'd1);
        issue_ri(rv_pkg::op_add, 5'd4, 5'd0, 12'h800);
        bubble();
        bubble();
        issue_rr(rv_pkg::op_slt, 5'd5, 5'd4, 5'd2);

        // rs1 and rs2 from different taps.
        issue_ri(rv_pkg::op_xor, 5'd6, 5'd2, 12'h0f0);
        issue_ri(rv_pkg::op_or, 5'd7, 5'd0, 12'h00f);
        issue_rr(rv_pkg::op_sra, 5'd8, 5'd6, 5'd7);
        issue_ri(rv_pkg::op_add, 5'd6, 5'd0, 12'hf81);
        bubble();
        issue_ri(rv_pkg::op_add, 5'd7, 5'd0, 12'h004);
        issue_rr(rv_pkg::op_srl, 5'd8, 5'd6, 5'd7);

        // youngest producer wins.
        issue_ri(rv_pkg::op_add, 5'd8, 5'd0, 12'd1);
        issue_ri(rv_pkg::op_add, 5'd8, 5'd0, 12'd2);
        issue_rr(rv_pkg::op_add, 5'd9, 5'd8, 5'd8);
        issue_ri(rv_pkg::op_add, 5'd8, 5'd0, 12'd3);
        bubble();
        issue_ri(rv_pkg::op_add, 5'd8, 5'd0, 12'd4);
        issue_rr(rv_pkg::op_add, 5'd9, 5'd8, 5'd0);

        // x0 stays zero.
        issue_ri(rv_pkg::op_add, 5'd0, 5'd0, 12'h5a5);
        issue_rr(rv_pkg::op_or, 5'd10, 5'd0, 5'd0);
        bubble();
        issue_rr(rv_pkg::op_add, 5'd11, 5'd0, 5'd1);

        // distance 4 and 5 read the register file.
        issue_ri(rv_pkg::op_add, 5'd12, 5'd0, 12'h321);
        repeat (3) bubble();
        issue_rr(rv_pkg::op_add, 5'd13, 5'd12, 5'd12);
        repeat (4) bubble();
        issue_rr(rv_pkg::op_sub, 5'd14, 5'd12, 5'd13);

        // small register subset keeps hazards frequent.
        for (int i = 0; i < num_random; i++) begin
            if ({$random(seed)} % 5 == 0) begin
                bubble();
            end else begin
                r_op      = 4'({$random(seed)} % 9);
                r_rd      = 5'({$random(seed)} % 6);
                r_rs1     = 5'({$random(seed)} % 6);
                r_rs2     = 5'({$random(seed)} % 6);
                r_use_imm = 1'($random(seed));
                r_imm     = 12'($random(seed));
                send_instr(1'b1, rv_pkg::alu_op_e'(r_op), r_rd, r_rs1, r_rs2, r_use_imm, r_imm);
            end
        end

        repeat (5) bubble();
        if (exp_q.size() != 0) begin
            abort_run($sformatf("only %0d of %0d instructions retired after the pipeline drained",
                                retired, sent));
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* flist.f */
rv_pkg.sv
issue_if.sv
regfile.sv
operand_fwd.sv
alu_stage.sv
retire_stage.sv
fwd_core.sv
fwd_core_props.sv
tb_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f flist.f -o tb_top_sim

# the simulator status is not trusted alone, the log decides.
./obj_dir/tb_top_sim 2>&1 | tee sim.log || true

if grep -q -E "TEST RESULT: FAIL|%Error" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
